// File: list.f
hw/isa_pkg.sv
hw/bus_pkg.sv
hw/cpu_decode.sv
hw/cpu_execute.sv
hw/cpu_result.sv
hw/host_port.sv
hw/cpu_top.sv
testbench/cpu_checker.sv
testbench/cpu_tb.sv

// File: testbench/cpu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_tb;

  logic               clk = 1'b0;
  logic               rst_n;
  bus_pkg::axil_req_t req;
  bus_pkg::axil_rsp_t rsp;
  logic               hlt;
  logic [15:0]        pc_port;
  logic [31:0]        lfsr_state = 32'h302d6b16;
  // program image built by each test before loading
  logic [15:0]        prog_q [$];

  always #4 clk = ~clk;

  cpu_top #(
    .prog_depth(256),
    .data_depth(256)
  ) dut0 (
    .clk      (clk),
    .rst_n    (rst_n),
    .axil_req (req),
    .axil_rsp (rsp),
    .hlt      (hlt),
    .pc       (pc_port)
  );

  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("TEST RESULT: FAIL");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      stop_with_failure($sformatf("MISMATCH at %0t: %s got %h expected %h",
                                  $time, name, got, exp));
    end
  endtask

  // galois lfsr for x^32 + x^22 + x^2 + x + 1
  // stepped once per bit taken
  function automatic logic [15:0] rand_bits(input int n);
    logic [15:0] v;
    logic        lsb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lsb        = lfsr_state[0];
      lfsr_state = lfsr_state >> 1;
      if (lsb) begin
        lfsr_state = lfsr_state ^ 32'h8020_0003;
      end
      v = {v[14:0], lsb};
    end
    return v;
  endfunction

  // reference model of the alu rules
  function automatic int signed_sum(input isa_pkg::opcode_e op, input logic [15:0] a,
                                    input logic [15:0] b);
    int sa;
    int sb;
    sa = int'($signed(a));
    sb = int'($signed(b));
    return (op == isa_pkg::SUB) ? sa - sb : sa + sb;
  endfunction

  function automatic logic ref_ovf(input isa_pkg::opcode_e op, input logic [15:0] a,
                                   input logic [15:0] b);
    int r;
    r = signed_sum(op, a, b);
    return (r > 32767) || (r < -32768);
  endfunction

  function automatic logic [15:0] ref_alu(input isa_pkg::opcode_e op, input logic [15:0] a,
                                          input logic [15:0] b);
    int          r;
    logic [15:0] res;
    r   = signed_sum(op, a, b);
    res = a;
    case (op)
      isa_pkg::ADD, isa_pkg::SUB: begin
        res = (r > 32767) ? 16'h7fff : (r < -32768) ? 16'h8000 : 16'(r);
      end
      isa_pkg::XOR: res = a ^ b;
      isa_pkg::AND: res = a & b;
      isa_pkg::OR:  res = a | b;
      isa_pkg::SLL: res = a << b[3:0];
      // one bit at a time with the sign bit copied in
      isa_pkg::SRA: begin
        for (int i = 0; i < b[3:0]; i++) begin
          res = {res[15], res[15:1]};
        end
      end
      isa_pkg::ROR: begin
        for (int i = 0; i < b[3:0]; i++) begin
          res = {res[0], res[15:1]};
        end
      end
      default: res = 16'd0;
    endcase
    return res;
  endfunction

  function automatic logic cond_taken(input isa_pkg::cond_e c, input logic z, input logic v,
                                      input logic n);
    case (c)
      isa_pkg::NE:  return !z;
      isa_pkg::EQ:  return z;
      isa_pkg::GT:  return !z && !n;
      isa_pkg::LT:  return n;
      isa_pkg::GE:  return !n;
      isa_pkg::LE:  return z || n;
      isa_pkg::OVF: return v;
      default:      return 1'b1;
    endcase
  endfunction

  function automatic logic is_shift(input isa_pkg::opcode_e op);
    return op inside {isa_pkg::SLL, isa_pkg::SRA, isa_pkg::ROR};
  endfunction

  // instruction encoders
  function automatic logic [15:0] enc_r(input isa_pkg::opcode_e op, input logic [3:0] rd,
                                        input logic [3:0] rs, input logic [3:0] rt);
    return {op, rd, rs, rt};
  endfunction

  function automatic logic [15:0] enc_i(input isa_pkg::opcode_e op, input logic [3:0] rd,
                                        input logic [7:0] imm);
    return {op, rd, imm};
  endfunction

  function automatic logic [15:0] enc_b(input isa_pkg::cond_e c, input logic [8:0] off);
    return {isa_pkg::B, c, off};
  endfunction

  function automatic logic [15:0] prog_addr(input int idx);
    return bus_pkg::PROG_BASE + 16'(2 * idx);
  endfunction

  function automatic logic [15:0] data_addr(input int idx);
    return bus_pkg::DATA_BASE + 16'(2 * idx);
  endfunction

  task automatic emit(input logic [15:0] w);
    prog_q.push_back(w);
  endtask

  // low byte then high byte with the flags untouched
  task automatic load_const(input logic [3:0] rd, input logic [15:0] v);
    emit(enc_i(isa_pkg::LLB, rd, v[7:0]));
    emit(enc_i(isa_pkg::LHB, rd, v[15:8]));
  endtask

  task automatic axil_write(input logic [15:0] addr, input logic [31:0] data,
                            output logic [1:0] resp);
    int n;
    @(posedge clk);
    req.awvalid <= 1'b1;
    req.awaddr  <= addr;
    req.wvalid  <= 1'b1;
    req.wdata   <= data;
    req.bready  <= 1'b1;
    n = 0;
    @(negedge clk);
    while (!(rsp.awready && rsp.wready)) begin
      n++;
      if (n > 16) begin
        stop_with_failure("timeout: write address and data were never accepted");
      end
      @(negedge clk);
    end
    // handshake completes at this edge
    @(posedge clk);
    req.awvalid <= 1'b0;
    req.wvalid  <= 1'b0;
    n = 0;
    @(negedge clk);
    while (!rsp.bvalid) begin
      n++;
      if (n > 16) begin
        stop_with_failure("timeout: no write response arrived");
      end
      @(negedge clk);
    end
    resp = rsp.bresp;
    @(posedge clk);
    req.bready <= 1'b0;
  endtask

  task automatic axil_read(input logic [15:0] addr, output logic [31:0] data,
                           output logic [1:0] resp);
    int n;
    @(posedge clk);
    req.arvalid <= 1'b1;
    req.araddr  <= addr;
    req.rready  <= 1'b1;
    n = 0;
    @(negedge clk);
    while (!rsp.arready) begin
      n++;
      if (n > 16) begin
        stop_with_failure("timeout: read address was never accepted");
      end
      @(negedge clk);
    end
    @(posedge clk);
    req.arvalid <= 1'b0;
    n = 0;
    @(negedge clk);
    while (!rsp.rvalid) begin
      n++;
      if (n > 16) begin
        stop_with_failure("timeout: no read data arrived");
      end
      @(negedge clk);
    end
    data = rsp.rdata;
    resp = rsp.rresp;
    @(posedge clk);
    req.rready <= 1'b0;
  endtask

  task automatic put_data(input int w, input logic [15:0] v);
    logic [1:0] resp;
    axil_write(data_addr(w), {16'd0, v}, resp);
    check_eq($sformatf("bresp data word %0d", w), resp, bus_pkg::OKAY);
  endtask

  task automatic expect_data(input int w, input logic [15:0] v);
    logic [31:0] data;
    logic [1:0]  resp;
    axil_read(data_addr(w), data, resp);
    check_eq($sformatf("rresp data word %0d", w), resp, bus_pkg::OKAY);
    check_eq($sformatf("data word %0d", w), data, {16'd0, v});
  endtask

  task automatic load_program();
    logic [1:0] resp;
    foreach (prog_q[i]) begin
      axil_write(prog_addr(i), {16'd0, prog_q[i]}, resp);
      check_eq($sformatf("bresp prog word %0d", i), resp, bus_pkg::OKAY);
    end
  endtask

  task automatic start_run();
    logic [1:0] resp;
    axil_write(bus_pkg::CTRL_ADDR, 32'd1, resp);
    check_eq("bresp ctrl", resp, bus_pkg::OKAY);
  endtask

  // cycles counts clocks after the start edge until hlt
  task automatic wait_halt(input int limit, output int cycles);
    @(negedge clk);
    cycles = 1;
    while (!hlt) begin
      if (cycles >= limit) begin
        stop_with_failure("timeout: core never reached HLT");
      end
      @(negedge clk);
      cycles++;
    end
  endtask

  task automatic run_program(input int limit, output int cycles);
    start_run();
    wait_halt(limit, cycles);
  endtask

  task automatic test_reset_state();
    logic [31:0] data;
    logic [1:0]  resp;
    axil_read(bus_pkg::CTRL_ADDR, data, resp);
    check_eq("rresp ctrl", resp, bus_pkg::OKAY);
    check_eq("ctrl run", data[bus_pkg::CTRL_RUN], 1'b0);
    check_eq("ctrl halted", data[bus_pkg::CTRL_HALTED], 1'b0);
    check_eq("ctrl pc", data[bus_pkg::CTRL_PC_LSB +: 16], 16'd0);
    check_eq("pc port", pc_port, 16'd0);
  endtask

  task automatic test_memory_access();
    logic [15:0] pw [4];
    logic [15:0] dw [4];
    logic [31:0] data;
    logic [1:0]  resp;
    int          cycles;
    for (int i = 0; i < 4; i++) begin
      pw[i] = rand_bits(16);
      dw[i] = rand_bits(16);
      axil_write(prog_addr(200 + i), {16'd0, pw[i]}, resp);
      check_eq("bresp prog", resp, bus_pkg::OKAY);
      put_data(200 + i, dw[i]);
    end
    for (int i = 0; i < 4; i++) begin
      axil_read(prog_addr(200 + i), data, resp);
      check_eq("rresp prog", resp, bus_pkg::OKAY);
      check_eq("prog word", data, {16'd0, pw[i]});
      expect_data(200 + i, dw[i]);
    end
    // r1 = 511 counted down to zero
    prog_q.delete();
    load_const(4'd1, 16'h01ff);
    load_const(4'd2, 16'h0001);
    emit(enc_r(isa_pkg::SUB, 4'd1, 4'd1, 4'd2));
    emit(enc_b(isa_pkg::NE, 9'h1fe));
    emit({isa_pkg::HLT, 12'd0});
    load_program();
    start_run();
    axil_read(bus_pkg::CTRL_ADDR, data, resp);
    check_eq("ctrl run and halted while running", data[1:0], 2'b01);
    axil_read(data_addr(200), data, resp);
    check_eq("rresp data while running", resp, bus_pkg::SLVERR);
    axil_write(data_addr(200), {16'd0, ~dw[0]}, resp);
    check_eq("bresp data while running", resp, bus_pkg::SLVERR);
    axil_read(prog_addr(200), data, resp);
    check_eq("rresp prog while running", resp, bus_pkg::SLVERR);
    wait_halt(4000, cycles);
    expect_data(200, dw[0]);
    axil_read(bus_pkg::CTRL_ADDR, data, resp);
    check_eq("ctrl after loop", data, {16'd12, 16'h0002});
  endtask

  task automatic test_alu_ops();
    isa_pkg::opcode_e ops [12];
    logic [15:0]      a [12];
    logic [15:0]      b [12];
    logic [3:0]       rt;
    int               cycles;
    for (int k = 0; k < 8; k++) begin
      ops[k] = isa_pkg::opcode_e'(k);
      a[k]   = rand_bits(16);
      b[k]   = is_shift(ops[k]) ? rand_bits(4) : rand_bits(16);
    end
    // saturation corners in both directions
    ops[8]  = isa_pkg::ADD;
    a[8]    = 16'h7000;
    b[8]    = 16'h2000;
    ops[9]  = isa_pkg::ADD;
    a[9]    = 16'h9000;
    b[9]    = 16'h9000;
    ops[10] = isa_pkg::SUB;
    a[10]   = 16'h8000;
    b[10]   = 16'h0001;
    ops[11] = isa_pkg::SUB;
    a[11]   = 16'h7fff;
    b[11]   = 16'hffff;
    prog_q.delete();
    for (int k = 0; k < 12; k++) begin
      rt = is_shift(ops[k]) ? b[k][3:0] : 4'd2;
      load_const(4'd1, a[k]);
      load_const(4'd2, b[k]);
      load_const(4'd4, 16'(2 * (64 + k)));
      emit(enc_r(ops[k], 4'd3, 4'd1, rt));
      emit(enc_r(isa_pkg::SW, 4'd3, 4'd4, 4'd0));
    end
    emit({isa_pkg::HLT, 12'd0});
    load_program();
    run_program(400, cycles);
    check_eq("alu program cycles", cycles, prog_q.size());
    for (int k = 0; k < 12; k++) begin
      expect_data(64 + k, ref_alu(ops[k], a[k], b[k]));
    end
  endtask

  task automatic test_branches();
    isa_pkg::opcode_e sop [4];
    logic [15:0]      sa [4];
    logic [15:0]      sb [4];
    logic [15:0]      res;
    logic             z;
    logic             v;
    logic             n;
    int               hlt_idx;
    int               cycles;
    sop = '{isa_pkg::SUB, isa_pkg::SUB, isa_pkg::SUB, isa_pkg::ADD};
    sa  = '{16'd5, 16'd5, 16'd1, 16'h7000};
    sb  = '{16'd5, 16'd1, 16'd5, 16'h2000};
    put_data(0, 16'hffff);
    for (int m = 100; m < 132; m++) begin
      put_data(m, 16'd0);
    end
    prog_q.delete();
    load_const(4'd1, 16'd5);
    load_const(4'd2, 16'd1);
    load_const(4'd7, 16'h5aa5);
    emit(enc_r(isa_pkg::SUB, 4'd1, 4'd1, 4'd2));
    emit(enc_b(isa_pkg::NE, 9'h1fe));
    emit(enc_r(isa_pkg::SW, 4'd1, 4'd0, 4'd0));
    // zero, positive, negative and overflow flag states
    for (int s = 0; s < 4; s++) begin
      load_const(4'd1, sa[s]);
      load_const(4'd2, sb[s]);
      emit(enc_r(sop[s], 4'd3, 4'd1, 4'd2));
      for (int c = 0; c < 8; c++) begin
        load_const(4'd4, 16'(2 * (100 + s * 8 + c)));
        emit(enc_b(isa_pkg::cond_e'(c), 9'd1));
        emit(enc_b(isa_pkg::ALWAYS, 9'd1));
        emit(enc_r(isa_pkg::SW, 4'd7, 4'd4, 4'd0));
      end
    end
    emit({isa_pkg::HLT, 12'd0});
    hlt_idx = prog_q.size() - 1;
    load_program();
    run_program(2000, cycles);
    check_eq("pc port at halt", pc_port, 16'(2 * hlt_idx));
    expect_data(0, 16'd0);
    for (int s = 0; s < 4; s++) begin
      res = ref_alu(sop[s], sa[s], sb[s]);
      z   = (res == 16'd0);
      n   = res[15];
      v   = ref_ovf(sop[s], sa[s], sb[s]);
      for (int c = 0; c < 8; c++) begin
        expect_data(100 + s * 8 + c,
                    cond_taken(isa_pkg::cond_e'(c), z, v, n) ? 16'h5aa5 : 16'd0);
      end
    end
  endtask

  task automatic test_loads_and_jumps();
    logic [15:0] xw;
    logic [15:0] yw;
    logic [15:0] zw;
    logic [31:0] data;
    logic [1:0]  resp;
    int          cycles;
    xw = rand_bits(16);
    yw = rand_bits(16);
    zw = rand_bits(16);
    put_data(20, xw);
    put_data(13, yw);
    put_data(27, zw);
    prog_q.delete();
    // odd base 41 drops to byte 40 which is word 20
    load_const(4'd1, 16'd41);
    emit(enc_r(isa_pkg::LW, 4'd2, 4'd1, 4'h9));
    emit(enc_r(isa_pkg::LW, 4'd3, 4'd1, 4'h7));
    emit(enc_r(isa_pkg::LW, 4'd4, 4'd1, 4'h0));
    // pcs at index 5 writes back 12
    emit(enc_i(isa_pkg::PCS, 4'd5, 8'd0));
    emit(enc_r(isa_pkg::SW, 4'd2, 4'd0, 4'd0));
    emit(enc_r(isa_pkg::SW, 4'd3, 4'd0, 4'd1));
    emit(enc_r(isa_pkg::SW, 4'd4, 4'd0, 4'd2));
    emit(enc_r(isa_pkg::SW, 4'd5, 4'd0, 4'd3));
    load_const(4'd7, 16'd20);
    emit(enc_r(isa_pkg::ADD, 4'd6, 4'd5, 4'd7));
    emit({isa_pkg::BR, isa_pkg::ALWAYS, 1'b0, 4'd6, 4'd0});
    // two skipped halts before the target halt at index 16
    emit({isa_pkg::HLT, 12'd0});
    emit({isa_pkg::HLT, 12'd0});
    emit({isa_pkg::HLT, 12'd0});
    load_program();
    for (int r = 0; r < 2; r++) begin
      for (int w = 0; w < 4; w++) begin
        put_data(w, 16'd0);
      end
      run_program(100, cycles);
      check_eq("jump program cycles", cycles, 15);
      check_eq("pc port at halt", pc_port, 16'd32);
      axil_read(bus_pkg::CTRL_ADDR, data, resp);
      check_eq("ctrl after jump program", data, {16'd32, 16'h0002});
      expect_data(0, yw);
      expect_data(1, zw);
      expect_data(2, xw);
      expect_data(3, 16'(2 * 5 + 2));
    end
  endtask

  initial begin
    rst_n = 1'b0;
    req   = '0;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    test_reset_state();
    test_memory_access();
    test_alu_ops();
    test_branches();
    test_loads_and_jumps();
    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

`default_nettype wire

// File: testbench/cpu_checker.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_checker (
  input wire logic               clk,
  input wire logic               rst_n,
  input wire bus_pkg::axil_req_t axil_req,
  input wire bus_pkg::axil_rsp_t axil_rsp,
  input wire logic [15:0]        pc,
  input wire logic               start,
  input wire logic               hlt
);

  // write response holds until bready
  bvalid_held: assert property (@(posedge clk) disable iff (!rst_n)
    axil_rsp.bvalid && !axil_req.bready |=> axil_rsp.bvalid && $stable(axil_rsp.bresp))
    else $error("write response dropped or changed before it was accepted");

  // read data holds until rready
  rvalid_held: assert property (@(posedge clk) disable iff (!rst_n)
    axil_rsp.rvalid && !axil_req.rready |=>
      axil_rsp.rvalid && $stable(axil_rsp.rdata) && $stable(axil_rsp.rresp))
    else $error("read response dropped or changed before it was accepted");

  // handshake outputs quiet right after reset
  quiet_after_reset: assert property (@(posedge clk)
    $rose(rst_n) |-> !(axil_rsp.awready || axil_rsp.wready || axil_rsp.bvalid ||
                       axil_rsp.arready || axil_rsp.rvalid))
    else $error("handshake output high in the first cycle after reset");

  // a halted core keeps its pc until the next start
  pc_held_in_halt: assert property (@(posedge clk) disable iff (!rst_n)
    hlt && !start |=> $stable(pc))
    else $error("pc moved while halted");

endmodule

bind host_port cpu_checker checker0 (
  .clk      (clk),
  .rst_n    (rst_n),
  .axil_req (axil_req),
  .axil_rsp (axil_rsp),
  .pc       (pc),
  .start    (start),
  .hlt      (hlt)
);

`default_nettype wire

// File: hw/cpu_top.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_top #(
  parameter int prog_depth = 256,
  parameter int data_depth = 256
) (
  input  wire logic               clk,
  input  wire logic               rst_n,
  input  wire bus_pkg::axil_req_t axil_req,
  output bus_pkg::axil_rsp_t      axil_rsp,
  output logic                    hlt,
  output logic [15:0]             pc
);

  isa_pkg::ctrl_t ctrl;
  logic [15:0]    instr;
  logic [15:0]    mem_rdata;
  logic [15:0]    mem_addr;
  logic [15:0]    rs_data;
  logic [15:0]    rt_data;
  logic [15:0]    alu_out;
  logic [15:0]    pc_next;
  logic           run;
  logic           start;

  // bus side, memories and run control
  host_port #(
    .prog_depth(prog_depth),
    .data_depth(data_depth)
  ) host0 (
    .clk       (clk),
    .rst_n     (rst_n),
    .axil_req  (axil_req),
    .axil_rsp  (axil_rsp),
    .pc        (pc),
    .mem_addr  (mem_addr),
    .mem_wdata (rt_data),
    .mem_we    (ctrl.mem_we),
    .halt      (ctrl.halt),
    .instr     (instr),
    .mem_rdata (mem_rdata),
    .run       (run),
    .start     (start),
    .hlt       (hlt)
  );

  cpu_decode decode0 (
    .instr (instr),
    .ctrl  (ctrl)
  );

  // pc, flags and all address arithmetic
  cpu_execute #(
    .prog_depth(prog_depth),
    .data_depth(data_depth)
  ) execute0 (
    .clk      (clk),
    .rst_n    (rst_n),
    .run      (run),
    .start    (start),
    .ctrl     (ctrl),
    .rs_data  (rs_data),
    .rt_data  (rt_data),
    .pc       (pc),
    .pc_next  (pc_next),
    .alu_out  (alu_out),
    .mem_addr (mem_addr)
  );

  cpu_result result0 (
    .clk       (clk),
    .rst_n     (rst_n),
    .run       (run),
    .ctrl      (ctrl),
    .alu_out   (alu_out),
    .mem_rdata (mem_rdata),
    .pc_next   (pc_next),
    .rs_data   (rs_data),
    .rt_data   (rt_data)
  );

endmodule

`default_nettype wire

// File: hw/host_port.sv
`timescale 1ns/1ps
`default_nettype none

module host_port #(
  parameter int prog_depth = 256,
  parameter int data_depth = 256
) (
  input  wire logic               clk,
  input  wire logic               rst_n,
  input  wire bus_pkg::axil_req_t axil_req,
  output bus_pkg::axil_rsp_t      axil_rsp,
  input  wire logic [15:0]        pc,
  input  wire logic [15:0]        mem_addr,
  input  wire logic [15:0]        mem_wdata,
  input  wire logic               mem_we,
  input  wire logic               halt,
  output logic [15:0]             instr,
  output logic [15:0]             mem_rdata,
  output logic                    run,
  output logic                    start,
  output logic                    hlt
);

  localparam int PROG_AW = $clog2(prog_depth);
  localparam int DATA_AW = $clog2(data_depth);

  typedef enum logic {
    IDLE,
    RESP
  } chan_state_e;

  chan_state_e      wr_state;
  chan_state_e      rd_state;
  logic             wr_rdy;
  logic             rd_rdy;
  logic             bvalid;
  logic             rvalid;
  bus_pkg::resp_e   bresp;
  bus_pkg::resp_e   rresp;
  logic [31:0]      rdata;
  logic [31:0]      rd_word;
  logic             halted;
  logic             wr_fire;
  logic             rd_fire;
  logic             wr_ok;
  logic             rd_ok;
  bus_pkg::region_e wr_region;
  bus_pkg::region_e rd_region;
  logic [15:0]      prog_mem [prog_depth];
  logic [15:0]      data_mem [data_depth];

  assign wr_region = bus_pkg::region_of(axil_req.awaddr);
  assign rd_region = bus_pkg::region_of(axil_req.araddr);
  assign wr_fire   = wr_rdy & axil_req.awvalid & axil_req.wvalid;
  assign rd_fire   = rd_rdy & axil_req.arvalid;

  // memories are closed to the host while the core runs
  always_comb begin
    case (wr_region)
      bus_pkg::CTRL: wr_ok = 1'b1;
      bus_pkg::PROG: wr_ok = ~run;
      bus_pkg::DATA: wr_ok = ~run;
      default:       wr_ok = 1'b0;
    endcase
    case (rd_region)
      bus_pkg::CTRL: rd_ok = 1'b1;
      bus_pkg::PROG: rd_ok = ~run;
      bus_pkg::DATA: rd_ok = ~run;
      default:       rd_ok = 1'b0;
    endcase
  end

  // start bit seen in the write handshake cycle
  assign start = wr_fire && (wr_region == bus_pkg::CTRL) &&
                 axil_req.wdata[bus_pkg::CTRL_RUN];

  // write channel, ready pulse then response
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_state <= IDLE;
      wr_rdy   <= 1'b0;
      bvalid   <= 1'b0;
    end else begin
      case (wr_state)
        IDLE: begin
          if (wr_fire) begin
            wr_rdy   <= 1'b0;
            bvalid   <= 1'b1;
            wr_state <= RESP;
          end else begin
            wr_rdy <= axil_req.awvalid & axil_req.wvalid;
          end
        end
        default: begin
          if (axil_req.bready) begin
            bvalid   <= 1'b0;
            wr_state <= IDLE;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (wr_fire) begin
      bresp <= wr_ok ? bus_pkg::OKAY : bus_pkg::SLVERR;
    end
  end

  // read channel, same shape as the write side
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rd_state <= IDLE;
      rd_rdy   <= 1'b0;
      rvalid   <= 1'b0;
    end else begin
      case (rd_state)
        IDLE: begin
          if (rd_fire) begin
            rd_rdy   <= 1'b0;
            rvalid   <= 1'b1;
            rd_state <= RESP;
          end else begin
            rd_rdy <= axil_req.arvalid;
          end
        end
        default: begin
          if (axil_req.rready) begin
            rvalid   <= 1'b0;
            rd_state <= IDLE;
          end
        end
      endcase
    end
  end

  always_comb begin
    case (rd_region)
      bus_pkg::CTRL: rd_word = {pc, 14'd0, halted, run};
      bus_pkg::PROG: rd_word = {16'd0, prog_mem[axil_req.araddr[PROG_AW:1]]};
      bus_pkg::DATA: rd_word = {16'd0, data_mem[axil_req.araddr[DATA_AW:1]]};
      default:       rd_word = 32'd0;
    endcase
  end

  // error reads return zero data
  always_ff @(posedge clk) begin
    if (rd_fire) begin
      rresp <= rd_ok ? bus_pkg::OKAY : bus_pkg::SLVERR;
      rdata <= rd_ok ? rd_word : 32'd0;
    end
  end

  // start wins over a halt in the same cycle
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      run    <= 1'b0;
      halted <= 1'b0;
    end else if (start) begin
      run    <= 1'b1;
      halted <= 1'b0;
    end else if (run && halt) begin
      run    <= 1'b0;
      halted <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_fire && wr_ok && wr_region == bus_pkg::PROG) begin
      prog_mem[axil_req.awaddr[PROG_AW:1]] <= axil_req.wdata[15:0];
    end
  end

  // host and core never write data memory in the same cycle
  always_ff @(posedge clk) begin
    if (run && mem_we) begin
      data_mem[mem_addr[DATA_AW:1]] <= mem_wdata;
    end else if (wr_fire && wr_ok && wr_region == bus_pkg::DATA) begin
      data_mem[axil_req.awaddr[DATA_AW:1]] <= axil_req.wdata[15:0];
    end
  end

  // asynchronous reads toward the core
  assign instr     = prog_mem[pc[PROG_AW:1]];
  assign mem_rdata = data_mem[mem_addr[DATA_AW:1]];
  assign hlt       = halted;

  always_comb begin
    axil_rsp.awready = wr_rdy;
    axil_rsp.wready  = wr_rdy;
    axil_rsp.bvalid  = bvalid;
    axil_rsp.bresp   = bresp;
    axil_rsp.arready = rd_rdy;
    axil_rsp.rvalid  = rvalid;
    axil_rsp.rdata   = rdata;
    axil_rsp.rresp   = rresp;
  end

endmodule

`default_nettype wire

// File: hw/cpu_result.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_result (
  input  wire logic           clk,
  input  wire logic           rst_n,
  input  wire logic           run,
  input  wire isa_pkg::ctrl_t ctrl,
  input  wire logic [15:0]    alu_out,
  input  wire logic [15:0]    mem_rdata,
  input  wire logic [15:0]    pc_next,
  output logic [15:0]         rs_data,
  output logic [15:0]         rt_data
);

  logic [15:0] regs [16];
  logic [15:0] wb_data;

  // writeback source
  always_comb begin
    case (ctrl.wb_sel)
      isa_pkg::MEM:     wb_data = mem_rdata;
      isa_pkg::PC_NEXT: wb_data = pc_next;
      default:          wb_data = alu_out;
    endcase
  end

  // r0 reads as zero whatever the array holds
  assign rs_data = (ctrl.rs == 4'd0) ? 16'd0 : regs[ctrl.rs];
  assign rt_data = (ctrl.rt == 4'd0) ? 16'd0 : regs[ctrl.rt];

  // reads see the old value, the write lands at the edge
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < 16; i++) begin
        regs[i] <= 16'd0;
      end
    end else if (run && ctrl.reg_we) begin
      regs[ctrl.rd] <= wb_data;
    end
  end

endmodule

`default_nettype wire

// File: hw/cpu_execute.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_execute #(
  parameter int prog_depth = 256,
  parameter int data_depth = 256
) (
  input  wire logic           clk,
  input  wire logic           rst_n,
  input  wire logic           run,
  input  wire logic           start,
  input  wire isa_pkg::ctrl_t ctrl,
  input  wire logic [15:0]    rs_data,
  input  wire logic [15:0]    rt_data,
  output logic [15:0]         pc,
  output logic [15:0]         pc_next,
  output logic [15:0]         alu_out,
  output logic [15:0]         mem_addr
);

  // byte address masks, depths are powers of two
  localparam logic [15:0] PC_MASK   = 16'(prog_depth * 2 - 2);
  localparam logic [15:0] DATA_MASK = 16'(data_depth * 2 - 2);

  isa_pkg::flags_t flags;
  logic [15:0]     opb;
  logic [3:0]      shamt;
  logic [15:0]     sum;
  logic [15:0]     diff;
  logic [31:0]     rot;
  logic            add_ovf;
  logic            sub_ovf;
  logic            v_new;
  logic            taken;
  logic [15:0]     br_off;
  logic [15:0]     mem_off;
  logic [15:0]     pc_new;

  // second operand is rt or the 4 bit shift amount
  assign opb   = ctrl.alu_imm ? {12'd0, ctrl.imm[3:0]} : rt_data;
  assign shamt = opb[3:0];
  assign sum   = rs_data + opb;
  assign diff  = rs_data - opb;
  // signed overflow from the operand and result signs
  assign add_ovf = (rs_data[15] == opb[15]) && (sum[15] != rs_data[15]);
  assign sub_ovf = (rs_data[15] != opb[15]) && (diff[15] != rs_data[15]);
  assign v_new   = (ctrl.op == isa_pkg::SUB) ? sub_ovf : add_ovf;
  // rotate through a doubled copy
  assign rot = {rs_data, rs_data} >> shamt;

  always_comb begin
    case (ctrl.op)
      // saturate toward the sign of the operands
      isa_pkg::ADD: alu_out = add_ovf ? (rs_data[15] ? 16'h8000 : 16'h7fff) : sum;
      isa_pkg::SUB: alu_out = sub_ovf ? (rs_data[15] ? 16'h8000 : 16'h7fff) : diff;
      isa_pkg::XOR: alu_out = rs_data ^ opb;
      isa_pkg::AND: alu_out = rs_data & opb;
      isa_pkg::OR:  alu_out = rs_data | opb;
      isa_pkg::SLL: alu_out = rs_data << shamt;
      isa_pkg::SRA: alu_out = 16'($signed(rs_data) >>> shamt);
      isa_pkg::ROR: alu_out = rot[15:0];
      isa_pkg::LLB: alu_out = {rs_data[15:8], ctrl.imm[7:0]};
      isa_pkg::LHB: alu_out = {ctrl.imm[7:0], rs_data[7:0]};
      default:      alu_out = 16'd0;
    endcase
  end

  // base with bit 0 cleared plus signed word offset
  assign mem_off  = {{11{ctrl.imm[3]}}, ctrl.imm[3:0], 1'b0};
  assign mem_addr = ({rs_data[15:1], 1'b0} + mem_off) & DATA_MASK;

  always_comb begin
    case (ctrl.cond)
      isa_pkg::NE:  taken = ~flags.z;
      isa_pkg::EQ:  taken = flags.z;
      isa_pkg::GT:  taken = ~flags.z & ~flags.n;
      isa_pkg::LT:  taken = flags.n;
      isa_pkg::GE:  taken = flags.z | ~flags.n;
      isa_pkg::LE:  taken = flags.z | flags.n;
      isa_pkg::OVF: taken = flags.v;
      default:      taken = 1'b1;
    endcase
  end

  // B offset counts words from pc + 2
  assign pc_next = (pc + 16'd2) & PC_MASK;
  assign br_off  = {{6{ctrl.imm[8]}}, ctrl.imm, 1'b0};

  always_comb begin
    if (ctrl.op == isa_pkg::B && taken) begin
      pc_new = (pc_next + br_off) & PC_MASK;
    end else if (ctrl.op == isa_pkg::BR && taken) begin
      pc_new = rs_data & PC_MASK;
    end else begin
      pc_new = pc_next;
    end
  end

  // HLT parks the pc on itself
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc <= 16'd0;
    end else if (start) begin
      pc <= 16'd0;
    end else if (run && !ctrl.halt) begin
      pc <= pc_new;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      flags <= '0;
    end else if (run) begin
      if (ctrl.set_zf) begin
        flags.z <= (alu_out == 16'd0);
      end
      if (ctrl.set_vn) begin
        flags.v <= v_new;
        flags.n <= alu_out[15];
      end
    end
  end

endmodule

`default_nettype wire

// File: hw/cpu_decode.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_decode (
  input  wire logic [15:0]    instr,
  output isa_pkg::ctrl_t      ctrl
);

  isa_pkg::instr_t fields;

  assign fields = isa_pkg::instr_t'(instr);

  always_comb begin
    // default is a no-op: no writes, no flag updates
    ctrl        = '0;
    ctrl.op     = fields.op;
    ctrl.rd     = fields.rd;
    ctrl.rs     = fields.rs;
    ctrl.rt     = fields.rt;
    ctrl.imm    = instr[8:0];
    ctrl.cond   = isa_pkg::cond_e'(instr[11:9]);
    ctrl.wb_sel = isa_pkg::ALU;

    case (fields.op)
      isa_pkg::ADD, isa_pkg::SUB: begin
        ctrl.reg_we = 1'b1;
        ctrl.set_zf = 1'b1;
        ctrl.set_vn = 1'b1;
      end
      isa_pkg::XOR, isa_pkg::AND, isa_pkg::OR: begin
        ctrl.reg_we = 1'b1;
        ctrl.set_zf = 1'b1;
      end
      // shift amount comes from imm[3:0], not rt
      isa_pkg::SLL, isa_pkg::SRA, isa_pkg::ROR: begin
        ctrl.reg_we  = 1'b1;
        ctrl.set_zf  = 1'b1;
        ctrl.alu_imm = 1'b1;
      end
      isa_pkg::LW: begin
        ctrl.reg_we = 1'b1;
        ctrl.wb_sel = isa_pkg::MEM;
      end
      // store data register sits in the rd field
      isa_pkg::SW: begin
        ctrl.mem_we = 1'b1;
        ctrl.rt     = fields.rd;
      end
      // old rd value is read back through the rs port
      isa_pkg::LLB, isa_pkg::LHB: begin
        ctrl.reg_we = 1'b1;
        ctrl.rs     = fields.rd;
      end
      isa_pkg::PCS: begin
        ctrl.reg_we = 1'b1;
        ctrl.wb_sel = isa_pkg::PC_NEXT;
      end
      isa_pkg::HLT: begin
        ctrl.halt = 1'b1;
      end
      // B and BR only steer the pc
      default: begin
        ctrl.reg_we = 1'b0;
      end
    endcase

    // r0 is hardwired, never write it
    if (fields.rd == 4'd0) begin
      ctrl.reg_we = 1'b0;
    end
  end

endmodule

`default_nettype wire

// File: hw/bus_pkg.sv
`default_nettype none

package bus_pkg;

  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    SLVERR = 2'b10
  } resp_e;

  // address bits 13:12 pick the region
  typedef enum logic [1:0] {
    CTRL = 2'd0,
    PROG = 2'd1,
    DATA = 2'd2
  } region_e;

  // host address map
  localparam logic [15:0] CTRL_ADDR = 16'h0000;
  localparam logic [15:0] PROG_BASE = 16'h1000;
  localparam logic [15:0] DATA_BASE = 16'h2000;
  localparam int unsigned REGION_MSB = 13;
  localparam int unsigned REGION_LSB = 12;

  // control register bit positions
  localparam int unsigned CTRL_RUN    = 0;
  localparam int unsigned CTRL_HALTED = 1;
  localparam int unsigned CTRL_PC_LSB = 16;

  typedef struct packed {
    logic        awvalid;
    logic [15:0] awaddr;
    logic        wvalid;
    logic [31:0] wdata;
    logic        bready;
    logic        arvalid;
    logic [15:0] araddr;
    logic        rready;
  } axil_req_t;

  typedef struct packed {
    logic        awready;
    logic        wready;
    logic        bvalid;
    resp_e       bresp;
    logic        arready;
    logic        rvalid;
    logic [31:0] rdata;
    resp_e       rresp;
  } axil_rsp_t;

  function automatic region_e region_of(input logic [15:0] addr);
    return region_e'(addr[REGION_MSB:REGION_LSB]);
  endfunction

endpackage

`default_nettype wire

// File: hw/isa_pkg.sv
`default_nettype none

package isa_pkg;

  // opcode in instr[15:12]
  typedef enum logic [3:0] {
    ADD = 4'd0,  SUB = 4'd1,  XOR = 4'd2,  AND = 4'd3,
    SLL = 4'd4,  SRA = 4'd5,  ROR = 4'd6,  OR  = 4'd7,
    LW  = 4'd8,  SW  = 4'd9,  LLB = 4'd10, LHB = 4'd11,
    B   = 4'd12, BR  = 4'd13, PCS = 4'd14, HLT = 4'd15
  } opcode_e;

  // branch condition in instr[11:9] for B and BR
  typedef enum logic [2:0] {
    NE = 3'd0, EQ = 3'd1, GT = 3'd2, LT = 3'd3,
    GE = 3'd4, LE = 3'd5, OVF = 3'd6, ALWAYS = 3'd7
  } cond_e;

  // which value lands in rd
  typedef enum logic [1:0] {
    ALU     = 2'd0,
    MEM     = 2'd1,
    PC_NEXT = 2'd2
  } wb_sel_e;

  typedef struct packed {
    logic z;
    logic v;
    logic n;
  } flags_t;

  // register form of the instruction word
  typedef struct packed {
    opcode_e    op;
    logic [3:0] rd;
    logic [3:0] rs;
    logic [3:0] rt;
  } instr_t;

  typedef struct packed {
    opcode_e    op;
    logic [3:0] rd;
    logic [3:0] rs;
    logic [3:0] rt;
    // raw low bits, each consumer picks its own slice
    logic [8:0] imm;
    cond_e      cond;
    logic       reg_we;
    logic       mem_we;
    logic       halt;
    wb_sel_e    wb_sel;
    logic       set_zf;
    logic       set_vn;
    logic       alu_imm;
  } ctrl_t;

endpackage

`default_nettype wire
